// ==== i3c_target.f ====
+incdir+verilog
verilog/i3c_target_pkg.sv
verilog/bus_monitor.sv
verilog/bus_rx_flow.sv
verilog/bus_tx_flow.sv
verilog/target_fsm.sv
verilog/i3c_target.sv
sim/tb_clock_gen.sv
sim/i3c_target_tb.sv

// ==== Makefile ====
# Verilator build and run for the I3C target testbench

VERILATOR ?= verilator
TOP       ?= i3c_target_tb
FILELIST  ?= i3c_target.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^Test passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/i3c_target_tb.sv ====
// Controller model runs SCL at 32 clock cycles per bit and holds SDA open-drain
`timescale 1ns/1ps
`include "i3c_target_params.svh"

module i3c_target_tb;

  localparam int SCL_HALF = 16;
  localparam int NUM_ROWS = 9;
  localparam logic [`I3C_ADDR_W-1:0] OWN_ADDR = 7'h2A;
  localparam logic [`I3C_ADDR_W-1:0] OTHER_ADDR = 7'h15;

  typedef struct packed {
    logic                   rd;
    logic [`I3C_ADDR_W-1:0] addr;
    logic                   dav;
    logic [3:0]             nbytes;
    logic                   bad_t;
    logic                   ack;
    logic [3:0]             last_pos;
  } test_row_t;

  logic                      clk;
  logic                      rst_n;
  logic                      scl;
  logic                      sda_ctl;
  logic                      sda_tgt;
  logic                      sda_line;
  logic [`I3C_ADDR_W-1:0]    dyn_addr;
  logic                      dyn_addr_valid;
  logic [`I3C_TIMER_W-1:0]   t_hd_dat;
  i3c_target_pkg::tx_byte_t  tx_byte;
  logic                      tx_valid;
  logic                      tx_ready;
  logic [`I3C_BYTE_W-1:0]    rx_byte;
  logic                      rx_valid;
  logic                      parity_err;
  i3c_target_pkg::bus_addr_t bus_addr;
  logic                      bus_addr_valid;
  logic                      xfer;

  test_row_t                 rows [NUM_ROWS];
  logic [`I3C_BYTE_W-1:0]    rx_got [$];
  i3c_target_pkg::tx_byte_t  tx_q [$];
  i3c_target_pkg::bus_addr_t addr_seen;
  int                        parity_cnt = 0;
  int                        addr_cnt = 0;
  int                        pop_cnt = 0;
  int                        errors = 0;
  int                        checks = 0;
  int                        cycles = 0;
  int                        limit;
  logic [15:0]               lfsr_state = 16'd15062;

  // Wired-AND of controller and target
  assign sda_line = sda_ctl & sda_tgt;

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  i3c_target i3c_target_inst (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .scl_i              (scl),
    .sda_i              (sda_line),
    .sda_o              (sda_tgt),
    .dyn_addr_i         (dyn_addr),
    .dyn_addr_valid_i   (dyn_addr_valid),
    .t_hd_dat_i         (t_hd_dat),
    .tx_byte_i          (tx_byte),
    .tx_valid_i         (tx_valid),
    .tx_ready_o         (tx_ready),
    .rx_byte_o          (rx_byte),
    .rx_valid_o         (rx_valid),
    .parity_err_o       (parity_err),
    .bus_addr_o         (bus_addr),
    .bus_addr_valid_o   (bus_addr_valid),
    .xfer_in_progress_o (xfer)
  );

  // Strobes collected away from the active clock edge
  always @(negedge clk) begin
    if (rx_valid) begin
      rx_got.push_back(rx_byte);
    end
    if (parity_err) begin
      parity_cnt++;
    end
    if (bus_addr_valid) begin
      addr_cnt++;
      addr_seen = bus_addr;
    end
  end

  // TX byte source popped on each ready pulse
  initial begin
    tx_valid = 1'b0;
    tx_byte  = '0;
    forever begin
      @(posedge clk);
      #1;
      if (tx_ready) begin
        pop_cnt++;
        if (tx_q.size() > 0) begin
          void'(tx_q.pop_front());
        end
      end
      tx_valid = (tx_q.size() > 0);
      tx_byte  = tx_valid ? tx_q[0] : '0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, target FSM stuck in %s", cycles,
               i3c_target_inst.u_target_fsm.state_q.name());
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [15:0] galois_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic next_rand_byte(output logic [`I3C_BYTE_W-1:0] b);
    b = '0;
    repeat (`I3C_BYTE_W) begin
      b = {b[`I3C_BYTE_W-2:0], lfsr_state[0]};
      lfsr_state = galois_step(lfsr_state);
    end
  endtask

  function automatic test_row_t make_row(input logic rd, input logic [`I3C_ADDR_W-1:0] addr,
                                         input logic dav, input int nbytes, input logic bad_t,
                                         input logic ack, input int last_pos);
    test_row_t r;
    r.rd       = rd;
    r.addr     = addr;
    r.dav      = dav;
    r.nbytes   = 4'(nbytes);
    r.bad_t    = bad_t;
    r.ack      = ack;
    r.last_pos = 4'(last_pos);
    return r;
  endfunction

  task automatic check_rx_byte(input logic [`I3C_BYTE_W-1:0] got,
                               input logic [`I3C_BYTE_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: rx byte 0x%02h, expected 0x%02h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input i3c_target_pkg::bus_addr_t got,
                            input i3c_target_pkg::bus_addr_t exp);
    checks++;
    if (got.raw !== exp.raw) begin
      $display("** Error at %0t: header addr 0x%02h rnw %0b, expected addr 0x%02h rnw %0b",
               $time, got.hdr.addr, got.hdr.rnw, exp.hdr.addr, exp.hdr.rnw);
      errors++;
    end
  endtask

  task automatic check_ack(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: header %s, expected %s", $time,
               got ? "ACK" : "NACK", exp ? "ACK" : "NACK");
      errors++;
    end
  endtask

  // Sampled T sits in the last field of got
  task automatic check_read_byte(input i3c_target_pkg::tx_byte_t got,
                                 input i3c_target_pkg::tx_byte_t exp);
    checks++;
    if (got.data !== exp.data || got.last !== ~exp.last) begin
      $display("** Error at %0t: read byte 0x%02h T %0b, expected 0x%02h T %0b",
               $time, got.data, got.last, exp.data, ~exp.last);
      errors++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      $display("** Error at %0t: %0d %s, expected %0d", $time, got, what, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic send_start();
    sda_ctl = 1'b0;
    wait_cycles(SCL_HALF);
    scl = 1'b0;
  endtask

  task automatic send_stop();
    wait_cycles(SCL_HALF / 2);
    sda_ctl = 1'b0;
    wait_cycles(SCL_HALF / 2);
    scl = 1'b1;
    wait_cycles(SCL_HALF);
    sda_ctl = 1'b1;
    wait_cycles(SCL_HALF);
  endtask

  // SDA set mid low phase and line sampled mid high phase
  task automatic clock_bit(input logic value, output logic sampled);
    wait_cycles(SCL_HALF / 2);
    sda_ctl = value;
    wait_cycles(SCL_HALF / 2);
    scl = 1'b1;
    wait_cycles(SCL_HALF / 2);
    sampled = sda_line;
    wait_cycles(SCL_HALF / 2);
    scl = 1'b0;
  endtask

  task automatic run_row(input int idx);
    test_row_t                 row;
    i3c_target_pkg::bus_addr_t hdr;
    i3c_target_pkg::tx_byte_t  got_rd;
    i3c_target_pkg::tx_byte_t  exp_rd;
    logic [`I3C_BYTE_W-1:0]    payload [16];
    logic                      line;
    logic                      tbit;
    string                     kind;
    int                        i;
    int                        b;
    int                        nbytes;
    int                        loaded;
    int                        n_good;
    int                        rx0;
    int                        par0;
    int                        addr0;
    int                        pop0;
    int                        err0;

    row    = rows[idx];
    nbytes = int'(row.nbytes);
    kind   = row.rd ? "read" : "write";
    err0   = errors;
    rx0    = rx_got.size();
    par0   = parity_cnt;
    addr0  = addr_cnt;
    pop0   = pop_cnt;
    for (i = 0; i < nbytes; i++) begin
      next_rand_byte(payload[i]);
    end
    // Last position past the byte count leaves the stream one byte short
    loaded = 0;
    if (row.rd) begin
      loaded = (int'(row.last_pos) < nbytes) ? nbytes : nbytes - 1;
      if (loaded < 0) begin
        loaded = 0;
      end
      tx_q.delete();
      for (i = 0; i < loaded; i++) begin
        exp_rd.data = payload[i];
        exp_rd.last = (i == int'(row.last_pos));
        tx_q.push_back(exp_rd);
      end
    end
    dyn_addr_valid = row.dav;
    wait_cycles(4);

    hdr.hdr.addr = row.addr;
    hdr.hdr.rnw  = row.rd;
    send_start();
    for (b = `I3C_BYTE_W - 1; b >= 0; b--) begin
      clock_bit(hdr.raw[b], line);
    end
    clock_bit(1'b1, line);
    check_ack(~line, row.ack);

    if (row.rd && row.ack) begin
      for (i = 0; i < nbytes; i++) begin
        for (b = `I3C_BYTE_W - 1; b >= 0; b--) begin
          clock_bit(1'b1, line);
          got_rd.data[b] = line;
        end
        clock_bit(1'b1, line);
        got_rd.last = line;
        if (i < loaded) begin
          exp_rd.data = payload[i];
          exp_rd.last = (i == int'(row.last_pos));
        end else begin
          exp_rd.data = 8'hFF;
          exp_rd.last = 1'b1;
        end
        check_read_byte(got_rd, exp_rd);
      end
    end else if (!row.rd) begin
      // Bytes still go out after a NACK and must be ignored
      for (i = 0; i < nbytes; i++) begin
        for (b = `I3C_BYTE_W - 1; b >= 0; b--) begin
          clock_bit(payload[i][b], line);
        end
        tbit = ~(^payload[i]);
        if (row.bad_t && i == nbytes - 1) begin
          tbit = ~tbit;
        end
        clock_bit(tbit, line);
      end
    end

    wait_cycles(4);
    check_flag(xfer, row.ack, "xfer_in_progress before STOP");
    send_stop();
    check_flag(xfer, 1'b0, "xfer_in_progress after STOP");
    check_count(addr_cnt - addr0, 1, "address strobes");
    check_addr(addr_seen, hdr);
    check_count(parity_cnt - par0, (row.ack && row.bad_t) ? 1 : 0, "parity errors");
    check_count(pop_cnt - pop0, row.ack ? loaded : 0, "TX pops");
    n_good = (!row.rd && row.ack) ? nbytes - (row.bad_t ? 1 : 0) : 0;
    check_count(rx_got.size() - rx0, n_good, "RX strobes");
    for (i = 0; i < n_good && rx0 + i < rx_got.size(); i++) begin
      check_rx_byte(rx_got[rx0 + i], payload[i]);
    end
    $display("test %0d: %s addr 0x%02h, %0d bytes: %s", idx, kind, row.addr, nbytes,
             (errors == err0) ? "ok" : "FAILED");
  endtask

  initial begin
    int i;
    int err0;

    scl            = 1'b1;
    sda_ctl        = 1'b1;
    dyn_addr       = OWN_ADDR;
    dyn_addr_valid = 1'b0;
    t_hd_dat       = 8'd2;

    rows[0] = make_row(1'b0, OWN_ADDR,   1'b1, 4, 1'b0, 1'b1, 0);
    rows[1] = make_row(1'b0, OWN_ADDR,   1'b1, 3, 1'b1, 1'b1, 0);
    rows[2] = make_row(1'b0, OTHER_ADDR, 1'b1, 2, 1'b0, 1'b0, 0);
    rows[3] = make_row(1'b0, OWN_ADDR,   1'b0, 2, 1'b0, 1'b0, 0);
    rows[4] = make_row(1'b1, OWN_ADDR,   1'b1, 3, 1'b0, 1'b1, 2);
    rows[5] = make_row(1'b1, OTHER_ADDR, 1'b1, 2, 1'b0, 1'b0, 1);
    rows[6] = make_row(1'b1, OWN_ADDR,   1'b1, 0, 1'b0, 1'b0, 0);
    rows[7] = make_row(1'b1, OWN_ADDR,   1'b1, 3, 1'b0, 1'b1, 15);
    rows[8] = make_row(1'b0, OWN_ADDR,   1'b1, 2, 1'b0, 1'b1, 0);

    // Header, ACK and each byte take 9 bits of 32 cycles
    limit = 1000;
    for (i = 0; i < NUM_ROWS; i++) begin
      limit += (int'(rows[i].nbytes) + 2) * 9 * 2 * SCL_HALF + 200;
    end

    @(posedge rst_n);
    wait_cycles(2);
    err0 = errors;
    check_flag(sda_tgt, 1'b1, "sda_o after reset");
    check_flag(rx_valid, 1'b0, "rx_valid_o after reset");
    check_flag(tx_ready, 1'b0, "tx_ready_o after reset");
    check_flag(parity_err, 1'b0, "parity_err_o after reset");
    check_flag(bus_addr_valid, 1'b0, "bus_addr_valid_o after reset");
    check_flag(xfer, 1'b0, "xfer_in_progress_o after reset");
    $display("reset state: %s", (errors == err0) ? "ok" : "FAILED");

    for (i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end

    $display("%0d tests, %0d checks, %0d errors", NUM_ROWS + 1, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim/tb_clock_gen.sv ====
// Reset is released 1 ns after the third rising clock edge
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD_NS = 4;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// ==== verilog/i3c_target.sv ====
// SDR private transfers only and sda_o must be wired-AND with the external SDA line
`timescale 1ns/1ps
`include "i3c_target_params.svh"

module i3c_target (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      scl_i,
  input  logic                      sda_i,
  output logic                      sda_o,
  input  logic [`I3C_ADDR_W-1:0]    dyn_addr_i,
  input  logic                      dyn_addr_valid_i,
  input  logic [`I3C_TIMER_W-1:0]   t_hd_dat_i,
  input  i3c_target_pkg::tx_byte_t  tx_byte_i,
  input  logic                      tx_valid_i,
  output logic                      tx_ready_o,
  output logic [`I3C_BYTE_W-1:0]    rx_byte_o,
  output logic                      rx_valid_o,
  output logic                      parity_err_o,
  output i3c_target_pkg::bus_addr_t bus_addr_o,
  output logic                      bus_addr_valid_o,
  output logic                      xfer_in_progress_o
);

  i3c_target_pkg::bus_state_t bus;
  logic                       rx_req_byte;
  logic                       rx_req_bit;
  logic [`I3C_BYTE_W-1:0]     rx_data;
  logic                       rx_done;
  logic                       tx_req_byte;
  logic                       tx_req_bit;
  logic [`I3C_BYTE_W-1:0]     tx_value;
  logic                       tx_done;

  bus_monitor u_bus_monitor (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .bus_o (bus)
  );

  bus_rx_flow u_bus_rx_flow (
    .clk_i,
    .rst_ni,
    .bus_i      (bus),
    .req_byte_i (rx_req_byte),
    .req_bit_i  (rx_req_bit),
    .rx_data_o  (rx_data),
    .rx_done_o  (rx_done)
  );

  bus_tx_flow u_bus_tx_flow (
    .clk_i,
    .rst_ni,
    .bus_i       (bus),
    .t_hd_dat_i,
    .req_byte_i  (tx_req_byte),
    .req_bit_i   (tx_req_bit),
    .req_value_i (tx_value),
    .tx_done_o   (tx_done),
    .sda_o
  );

  target_fsm u_target_fsm (
    .clk_i,
    .rst_ni,
    .bus_i         (bus),
    .dyn_addr_i,
    .dyn_addr_valid_i,
    .rx_req_byte_o (rx_req_byte),
    .rx_req_bit_o  (rx_req_bit),
    .rx_data_i     (rx_data),
    .rx_done_i     (rx_done),
    .tx_req_byte_o (tx_req_byte),
    .tx_req_bit_o  (tx_req_bit),
    .tx_value_o    (tx_value),
    .tx_done_i     (tx_done),
    .tx_byte_i,
    .tx_valid_i,
    .tx_ready_o,
    .rx_byte_o,
    .rx_valid_o,
    .parity_err_o,
    .bus_addr_o,
    .bus_addr_valid_o,
    .xfer_in_progress_o
  );

endmodule

// ==== verilog/target_fsm.sv ====
// Private SDR reads and writes only with no CCC, IBI or HDR support
`timescale 1ns/1ps
`include "i3c_target_params.svh"

module target_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_target_pkg::bus_state_t bus_i,
  input  logic [`I3C_ADDR_W-1:0]     dyn_addr_i,
  input  logic                       dyn_addr_valid_i,
  output logic                       rx_req_byte_o,
  output logic                       rx_req_bit_o,
  input  logic [`I3C_BYTE_W-1:0]     rx_data_i,
  input  logic                       rx_done_i,
  output logic                       tx_req_byte_o,
  output logic                       tx_req_bit_o,
  output logic [`I3C_BYTE_W-1:0]     tx_value_o,
  input  logic                       tx_done_i,
  input  i3c_target_pkg::tx_byte_t   tx_byte_i,
  input  logic                       tx_valid_i,
  output logic                       tx_ready_o,
  output logic [`I3C_BYTE_W-1:0]     rx_byte_o,
  output logic                       rx_valid_o,
  output logic                       parity_err_o,
  output i3c_target_pkg::bus_addr_t  bus_addr_o,
  output logic                       bus_addr_valid_o,
  output logic                       xfer_in_progress_o
);

  i3c_target_pkg::fsm_state_e state_q;
  i3c_target_pkg::fsm_state_e state_d;
  i3c_target_pkg::bus_addr_t  hdr_rx;
  logic                       hdr_match;
  logic                       hdr_ack;
  logic                       read_next;
  logic                       rx_req_byte_d;
  logic                       rx_req_bit_d;
  logic                       tx_req_byte_d;
  logic                       tx_req_bit_d;
  logic                       tx_ready_d;
  logic [`I3C_BYTE_W-1:0]     tx_value_d;
  logic                       addr_valid_d;
  logic                       check_d;
  logic                       rd_last_q;
  logic [`I3C_BYTE_W-1:0]     wr_byte_q;
  logic                       chk_pend_q;
  logic                       chk_ok_q;

  assign hdr_rx.raw = rx_data_i;

  // Reads are only ACKed with a byte ready to send
  assign hdr_match = dyn_addr_valid_i && (hdr_rx.hdr.addr == dyn_addr_i) &&
                     (!hdr_rx.hdr.rnw || tx_valid_i);

  always_comb begin
    state_d       = state_q;
    rx_req_byte_d = 1'b0;
    rx_req_bit_d  = 1'b0;
    tx_req_byte_d = 1'b0;
    tx_req_bit_d  = 1'b0;
    tx_ready_d    = 1'b0;
    tx_value_d    = tx_value_o;
    addr_valid_d  = 1'b0;
    check_d       = 1'b0;
    hdr_ack       = 1'b0;
    read_next     = 1'b0;
    if (bus_i.stop_det) begin
      state_d = i3c_target_pkg::Idle;
    end else if (bus_i.start_det || bus_i.rstart_det) begin
      state_d       = i3c_target_pkg::Addr;
      rx_req_byte_d = 1'b1;
    end else begin
      unique case (state_q)
        i3c_target_pkg::Idle, i3c_target_pkg::Wait: begin
        end
        i3c_target_pkg::Addr: begin
          if (rx_done_i) begin
            addr_valid_d = 1'b1;
            if (hdr_match) begin
              state_d      = i3c_target_pkg::AddrAck;
              hdr_ack      = 1'b1;
              tx_req_bit_d = 1'b1;
              tx_value_d   = '0;
            end else begin
              state_d = i3c_target_pkg::Wait;
            end
          end
        end
        i3c_target_pkg::AddrAck: begin
          if (tx_done_i) begin
            if (bus_addr_o.hdr.rnw) begin
              read_next = 1'b1;
            end else begin
              state_d       = i3c_target_pkg::WrData;
              rx_req_byte_d = 1'b1;
            end
          end
        end
        i3c_target_pkg::WrData: begin
          if (rx_done_i) begin
            state_d      = i3c_target_pkg::WrTbit;
            rx_req_bit_d = 1'b1;
          end
        end
        i3c_target_pkg::WrTbit: begin
          if (rx_done_i) begin
            state_d       = i3c_target_pkg::WrData;
            rx_req_byte_d = 1'b1;
            check_d       = 1'b1;
          end
        end
        i3c_target_pkg::RdData: begin
          if (tx_done_i) begin
            state_d      = i3c_target_pkg::RdTbit;
            tx_req_bit_d = 1'b1;
            tx_value_d   = {{(`I3C_BYTE_W-1){1'b0}}, ~rd_last_q};
          end
        end
        i3c_target_pkg::RdTbit: begin
          if (tx_done_i) begin
            if (rd_last_q) begin
              state_d = i3c_target_pkg::Wait;
            end else begin
              read_next = 1'b1;
            end
          end
        end
      endcase
      // Empty stream sends 0xFF marked as last
      if (read_next) begin
        state_d       = i3c_target_pkg::RdData;
        tx_req_byte_d = 1'b1;
        tx_ready_d    = tx_valid_i;
        tx_value_d    = tx_valid_i ? tx_byte_i.data : '1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= i3c_target_pkg::Idle;
      rx_req_byte_o      <= 1'b0;
      rx_req_bit_o       <= 1'b0;
      tx_req_byte_o      <= 1'b0;
      tx_req_bit_o       <= 1'b0;
      tx_ready_o         <= 1'b0;
      bus_addr_valid_o   <= 1'b0;
      xfer_in_progress_o <= 1'b0;
      rd_last_q          <= 1'b0;
      chk_pend_q         <= 1'b0;
      chk_ok_q           <= 1'b0;
      rx_valid_o         <= 1'b0;
      parity_err_o       <= 1'b0;
    end else begin
      state_q          <= state_d;
      rx_req_byte_o    <= rx_req_byte_d;
      rx_req_bit_o     <= rx_req_bit_d;
      tx_req_byte_o    <= tx_req_byte_d;
      tx_req_bit_o     <= tx_req_bit_d;
      tx_ready_o       <= tx_ready_d;
      bus_addr_valid_o <= addr_valid_d;
      if (read_next) begin
        rd_last_q <= tx_valid_i ? tx_byte_i.last : 1'b1;
      end
      // Odd parity over data and T
      chk_pend_q <= check_d;
      if (check_d) begin
        chk_ok_q <= ^{wr_byte_q, rx_data_i[0]};
      end
      rx_valid_o   <= chk_pend_q & chk_ok_q;
      parity_err_o <= chk_pend_q & ~chk_ok_q;
      if (bus_i.stop_det) begin
        xfer_in_progress_o <= 1'b0;
      end else if (hdr_ack) begin
        xfer_in_progress_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    tx_value_o <= tx_value_d;
    if (addr_valid_d) begin
      bus_addr_o <= hdr_rx;
    end
    if (state_q == i3c_target_pkg::WrData && rx_done_i) begin
      wr_byte_q <= rx_data_i;
    end
    if (chk_pend_q && chk_ok_q) begin
      rx_byte_o <= wr_byte_q;
    end
  end

endmodule

// ==== verilog/bus_tx_flow.sv ====
// Open-drain only so a driven 1 releases SDA and relies on the external pull-up
`timescale 1ns/1ps
`include "i3c_target_params.svh"

module bus_tx_flow (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_target_pkg::bus_state_t bus_i,
  input  logic [`I3C_TIMER_W-1:0]    t_hd_dat_i,
  input  logic                       req_byte_i,
  input  logic                       req_bit_i,
  input  logic [`I3C_BYTE_W-1:0]     req_value_i,
  output logic                       tx_done_o,
  output logic                       sda_o
);

  logic [`I3C_BYTE_W-1:0]   shift_q;
  logic [`I3C_BYTE_W-1:0]   shift_cur;
  logic [`I3C_BITCNT_W-1:0] cnt_q;
  logic [`I3C_BITCNT_W-1:0] cnt_cur;
  logic                     active_q;
  logic                     active_cur;
  logic [`I3C_TIMER_W-1:0]  hold_q;
  logic                     hold_pend_q;
  logic                     hold_expired;
  logic                     drive;
  logic                     abort;

  assign abort        = bus_i.start_det | bus_i.rstart_det | bus_i.stop_det;
  assign hold_expired = hold_pend_q && (hold_q <= `I3C_TIMER_W'(1));

  // A request arriving while the hold timer runs is driven at its expiry
  always_comb begin
    shift_cur  = shift_q;
    cnt_cur    = cnt_q;
    active_cur = active_q;
    if (req_byte_i) begin
      shift_cur  = req_value_i;
      cnt_cur    = `I3C_BITCNT_W'(`I3C_BYTE_W);
      active_cur = 1'b1;
    end else if (req_bit_i) begin
      shift_cur  = {req_value_i[0], {(`I3C_BYTE_W-1){1'b0}}};
      cnt_cur    = `I3C_BITCNT_W'(1);
      active_cur = 1'b1;
    end
  end

  // All bits out and the last one held through its high phase
  assign tx_done_o = active_q && bus_i.scl.neg_edge && (cnt_q == '0);
  assign drive     = hold_expired && active_cur && (cnt_cur != '0) && !tx_done_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      cnt_q       <= '0;
      hold_q      <= '0;
      hold_pend_q <= 1'b0;
      sda_o       <= 1'b1;
    end else if (abort) begin
      active_q    <= 1'b0;
      hold_pend_q <= 1'b0;
      sda_o       <= 1'b1;
    end else begin
      active_q <= active_cur;
      cnt_q    <= cnt_cur;
      if (bus_i.scl.neg_edge) begin
        hold_q      <= t_hd_dat_i;
        hold_pend_q <= 1'b1;
      end else if (hold_expired) begin
        hold_pend_q <= 1'b0;
      end else if (hold_q != '0) begin
        hold_q <= hold_q - `I3C_TIMER_W'(1);
      end
      if (tx_done_o) begin
        active_q <= 1'b0;
        sda_o    <= 1'b1;
      end else if (drive) begin
        sda_o <= shift_cur[`I3C_BYTE_W-1];
        cnt_q <= cnt_cur - `I3C_BITCNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q <= drive ? {shift_cur[`I3C_BYTE_W-2:0], 1'b0} : shift_cur;
  end

endmodule

// ==== verilog/bus_rx_flow.sv ====
// Samples SDA only on SCL rising edges and does no glitch filtering
`timescale 1ns/1ps
`include "i3c_target_params.svh"

module bus_rx_flow (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_target_pkg::bus_state_t bus_i,
  input  logic                       req_byte_i,
  input  logic                       req_bit_i,
  output logic [`I3C_BYTE_W-1:0]     rx_data_o,
  output logic                       rx_done_o
);

  logic [`I3C_BITCNT_W-1:0] cnt_q;
  logic [`I3C_BYTE_W-1:0]   shift_q;
  logic                     active_q;
  logic                     sample;
  logic                     abort;

  assign abort  = bus_i.start_det | bus_i.rstart_det | bus_i.stop_det;
  assign sample = active_q & bus_i.scl.pos_edge;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q  <= 1'b0;
      cnt_q     <= '0;
      rx_done_o <= 1'b0;
    end else begin
      rx_done_o <= 1'b0;
      if (abort) begin
        active_q <= 1'b0;
      end else if (req_byte_i || req_bit_i) begin
        active_q <= 1'b1;
        cnt_q    <= req_byte_i ? `I3C_BITCNT_W'(`I3C_BYTE_W) : `I3C_BITCNT_W'(1);
      end else if (sample) begin
        cnt_q <= cnt_q - `I3C_BITCNT_W'(1);
        if (cnt_q == `I3C_BITCNT_W'(1)) begin
          active_q  <= 1'b0;
          rx_done_o <= 1'b1;
        end
      end
    end
  end

  // Cleared on request so a single bit lands in bit 0
  always_ff @(posedge clk_i) begin
    if (req_byte_i || req_bit_i) begin
      shift_q <= '0;
    end else if (sample) begin
      shift_q <= {shift_q[`I3C_BYTE_W-2:0], bus_i.sda.value};
    end
  end

  assign rx_data_o = shift_q;

endmodule

// ==== verilog/bus_monitor.sv ====
// Assumes clk_i runs at least four times faster than SCL so that no pin edge is missed
`timescale 1ns/1ps
`include "i3c_target_params.svh"

module bus_monitor (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,
  input  logic                       sda_i,
  output i3c_target_pkg::bus_state_t bus_o
);

  // Bit 1 is SCL and bit 0 is SDA, stage 0 is the newest sample
  logic [`I3C_SYNC_STAGES-1:0][1:0] sync_q;
  logic                             scl_s;
  logic                             sda_s;
  logic                             scl_high;
  logic                             sda_fall;
  logic                             sda_rise;
  logic                             busy_q;

  function automatic i3c_target_pkg::line_state_t line_update(input logic prev,
                                                              input logic cur);
    i3c_target_pkg::line_state_t ls;
    ls.value    = cur;
    ls.pos_edge = cur & ~prev;
    ls.neg_edge = ~cur & prev;
    return ls;
  endfunction

  assign scl_s = sync_q[`I3C_SYNC_STAGES-1][1];
  assign sda_s = sync_q[`I3C_SYNC_STAGES-1][0];

  // SCL high on both the current and the previous sample
  assign scl_high = scl_s & bus_o.scl.value;
  assign sda_fall = ~sda_s & bus_o.sda.value;
  assign sda_rise = sda_s & ~bus_o.sda.value;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[`I3C_SYNC_STAGES-2:0], {scl_i, sda_i}};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_o           <= '0;
      bus_o.scl.value <= 1'b1;
      bus_o.sda.value <= 1'b1;
      busy_q          <= 1'b0;
    end else begin
      bus_o.scl        <= line_update(bus_o.scl.value, scl_s);
      bus_o.sda        <= line_update(bus_o.sda.value, sda_s);
      bus_o.start_det  <= scl_high & sda_fall & ~busy_q;
      bus_o.rstart_det <= scl_high & sda_fall & busy_q;
      bus_o.stop_det   <= scl_high & sda_rise;
      if (scl_high && sda_fall) begin
        busy_q <= 1'b1;
      end else if (scl_high && sda_rise) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/i3c_target_pkg.sv ====
// Shared types for the target sized by the macros of the params header
`include "i3c_target_params.svh"

package i3c_target_pkg;

  // Level and one-cycle edge flags of one bus line
  typedef struct packed {
    logic value;
    logic pos_edge;
    logic neg_edge;
  } line_state_t;

  typedef struct packed {
    line_state_t scl;
    line_state_t sda;
    logic        start_det;
    logic        rstart_det;
    logic        stop_det;
  } bus_state_t;

  typedef struct packed {
    logic [`I3C_BYTE_W-1:0] data;
    logic                   last;
  } tx_byte_t;

  typedef struct packed {
    logic [`I3C_ADDR_W-1:0] addr;
    logic                   rnw;
  } addr_hdr_t;

  // Address byte seen raw or split into address and RnW
  typedef union packed {
    logic [`I3C_BYTE_W-1:0] raw;
    addr_hdr_t              hdr;
  } bus_addr_t;

  typedef enum logic [2:0] {
    Idle,
    Addr,
    AddrAck,
    WrData,
    WrTbit,
    RdData,
    RdTbit,
    Wait
  } fsm_state_e;

endpackage

// ==== verilog/i3c_target_params.svh ====
// Byte and address widths follow I3C SDR framing and should not be changed
`ifndef I3C_TARGET_PARAMS_SVH
`define I3C_TARGET_PARAMS_SVH

// Bus byte and target address
`define I3C_BYTE_W 8
`define I3C_ADDR_W 7

// Must hold the value of I3C_BYTE_W
`define I3C_BITCNT_W 4

// Width of the hold counter and of t_hd_dat_i
`define I3C_TIMER_W 8

// Pin synchronizer depth
`define I3C_SYNC_STAGES 2

`endif
